// ==== lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define CSR_ADDR_W  12

`define DMEM_WORDS  256
`define DMEM_AW     $clog2(`DMEM_WORDS)  // word address bits

`define IQ_DEPTH    2   // also the credit count after reset and flush
`define SB_DEPTH    4

// field values while not valid
`define ADDR_INVALID     32'h0
`define DATA_INVALID     32'h0
`define REG_ADDR_INVALID 5'h0
`define CSR_ADDR_INVALID 12'h0
`define EN_INVALID       1'b0

`endif

// ==== lsu_pkg.sv ====
`include "lsu_params.svh"

package lsu_pkg;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_CSRW
    } lsu_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_LD_MISALIGN,
        EXC_ST_MISALIGN
    } except_e;

    // executed op handed over by the execute side
    typedef struct packed {
        lsu_op_e                 op;
        logic [`XLEN-1:0]        pc;
        logic [`XLEN-1:0]        inst;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        result;   // alu value or csr data
        logic [`XLEN-1:0]        addr;     // byte address or csr index
        logic [`XLEN-1:0]        st_data;
    } ex_op_t;

    typedef struct packed {
        logic [`XLEN-1:0]        pc;
        logic [`XLEN-1:0]        inst;
        logic [`REG_ADDR_W-1:0]  rw_addr;
        logic                    rw_en;
        logic [`XLEN-1:0]        rw_data;
        logic                    csr_wen;
        logic [`CSR_ADDR_W-1:0]  csr_waddr;
        logic [`XLEN-1:0]        csr_wdata;
        logic                    st_valid;
        logic [`XLEN-1:0]        st_paddr;
        logic [`XLEN-1:0]        st_data;
        except_e                 except_type;
    } mem_info_t;

    typedef struct packed {
        logic [`XLEN-1:0]        pc;
        logic [`REG_ADDR_W-1:0]  rd;
        logic                    rw_en;
        logic [`XLEN-1:0]        rw_data;
        logic                    csr_wen;
        logic [`CSR_ADDR_W-1:0]  csr_waddr;
        logic [`XLEN-1:0]        csr_wdata;
        except_e                 except_type;
    } retire_t;

    typedef struct packed {
        logic                    en;
        logic                    we;
        logic [`DMEM_AW-1:0]     addr;     // word address
        logic [`XLEN-1:0]        wdata;
    } mem_req_t;

endpackage

// ==== data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module data_ram (
    input  logic              clk,
    input  lsu_pkg::mem_req_t ram_req,
    output logic [`XLEN-1:0]  rdata
);
    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++)
            mem[i] = '0;
    end

    // rdata only moves on a read
    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            if (ram_req.we)
                mem[ram_req.addr] <= ram_req.wdata;
            else
                rdata <= mem[ram_req.addr];
        end
    end

endmodule

// ==== dmem_arbiter.sv ====
`timescale 1ns/1ps

module dmem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  lsu_pkg::mem_req_t ld_req,
    input  lsu_pkg::mem_req_t st_req,
    input  logic              sb_full,
    output logic              ld_gnt,
    output logic              st_gnt,
    output lsu_pkg::mem_req_t ram_req
);
    logic rd_busy;  // load read data returns this cycle
    logic ld_go;

    // the return cycle of a load read belongs to the drain
    assign ld_go  = ld_req.en && !rd_busy;
    assign st_gnt = st_req.en && (sb_full || !ld_go);
    assign ld_gnt = ld_go && !st_gnt;

    always_comb begin
        if (st_gnt)
            ram_req = st_req;
        else if (ld_gnt)
            ram_req = ld_req;
        else
            ram_req = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            rd_busy <= 1'b0;
        else
            rd_busy <= ld_gnt;
    end

endmodule

// ==== store_buffer.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module store_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sb_push,
    input  lsu_pkg::mem_req_t   sb_data,
    input  logic                st_gnt,
    input  logic [`DMEM_AW-1:0] fwd_addr,
    output logic                sb_full,
    output lsu_pkg::mem_req_t   st_req,
    output logic                fwd_hit,
    output logic [`XLEN-1:0]    fwd_data
);
    import lsu_pkg::*;

    localparam int SB_AW = $clog2(`SB_DEPTH);

    mem_req_t         sb_q [`SB_DEPTH];
    logic [SB_AW-1:0] rd_ptr;
    logic [SB_AW-1:0] wr_ptr;
    logic [SB_AW:0]   cnt;

    assign sb_full = cnt == (SB_AW+1)'(`SB_DEPTH);
    assign st_req  = (cnt != '0) ? sb_q[rd_ptr] : '0;  // head offered to the arbiter

    // walk oldest to youngest so the last match wins
    always_comb begin
        logic [SB_AW-1:0] slot;
        fwd_hit  = 1'b0;
        fwd_data = `DATA_INVALID;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            slot = rd_ptr + SB_AW'(i);
            if ((SB_AW+1)'(i) < cnt && sb_q[slot].addr == fwd_addr) begin
                fwd_hit  = 1'b1;
                fwd_data = sb_q[slot].wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sb_push)
            sb_q[wr_ptr] <= sb_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (sb_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (st_gnt)
                rd_ptr <= rd_ptr + 1'b1;
            cnt <= cnt + (SB_AW+1)'(sb_push) - (SB_AW+1)'(st_gnt);
        end
    end

endmodule

// ==== wb_stage.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module wb_stage (
    input  logic               wb_valid,
    input  lsu_pkg::mem_info_t wb_info,
    input  logic               sb_full,
    output logic               wb_ready,
    output logic               retire_valid,
    output lsu_pkg::retire_t   retire,
    output logic               sb_push,
    output lsu_pkg::mem_req_t  sb_data
);
    import lsu_pkg::*;

    logic is_exc;
    logic is_st;

    assign is_exc = wb_info.except_type != EXC_NONE;
    assign is_st  = wb_info.st_valid && !is_exc;

    // only a store waits, and only on a full buffer
    assign wb_ready     = !(is_st && sb_full);
    assign retire_valid = wb_valid && wb_ready;

    always_comb begin
        retire.pc          = wb_info.pc;
        retire.rd          = wb_info.rw_addr;
        retire.rw_en       = wb_info.rw_en && !is_exc;
        retire.rw_data     = wb_info.rw_data;
        retire.csr_wen     = wb_info.csr_wen && !is_exc;
        retire.csr_waddr   = wb_info.csr_waddr;
        retire.csr_wdata   = wb_info.csr_wdata;
        retire.except_type = wb_info.except_type;
    end

    assign sb_push = retire_valid && is_st;

    always_comb begin
        sb_data.en    = 1'b1;
        sb_data.we    = 1'b1;
        sb_data.addr  = wb_info.st_paddr[`DMEM_AW+1:2];  // byte to word address
        sb_data.wdata = wb_info.st_data;
    end

endmodule

// ==== mem_wb_reg.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module mem_wb_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_valid,
    input  lsu_pkg::mem_info_t mem_info,
    input  logic               wb_ready,
    output logic               mem_ready,
    output logic               wb_valid,
    output lsu_pkg::mem_info_t wb_info
);
    import lsu_pkg::*;

    localparam mem_info_t INFO_INVALID = '{
        pc:          `ADDR_INVALID,
        inst:        `DATA_INVALID,
        rw_addr:     `REG_ADDR_INVALID,
        rw_en:       `EN_INVALID,
        rw_data:     `DATA_INVALID,
        csr_wen:     `EN_INVALID,
        csr_waddr:   `CSR_ADDR_INVALID,
        csr_wdata:   `DATA_INVALID,
        st_valid:    `EN_INVALID,
        st_paddr:    `ADDR_INVALID,
        st_data:     `DATA_INVALID,
        except_type: EXC_NONE
    };

    logic valid_q;

    assign mem_ready = !valid_q || (wb_ready && !stall);
    assign wb_valid  = valid_q && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q <= 1'b0;
        end else if (mem_ready) begin
            valid_q <= mem_valid;
        end
    end

    // payload held while not ready
    always_ff @(posedge clk) begin
        if (flush) begin
            wb_info <= INFO_INVALID;
        end else if (mem_valid && mem_ready) begin
            wb_info <= mem_info;
        end
    end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module mem_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                ex_valid,
    input  lsu_pkg::ex_op_t     ex_op,
    input  logic                mem_ready,
    input  logic                ld_gnt,
    input  logic [`XLEN-1:0]    ld_rdata,
    input  logic                fwd_hit,
    input  logic [`XLEN-1:0]    fwd_data,
    output logic                credit_ret,
    output logic                mem_valid,
    output lsu_pkg::mem_info_t  mem_info,
    output lsu_pkg::mem_req_t   ld_req,
    output logic [`DMEM_AW-1:0] fwd_addr
);
    import lsu_pkg::*;

    localparam int IQ_AW = $clog2(`IQ_DEPTH);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        WAIT_DATA
    } ld_state_e;

    ex_op_t           iq_mem [`IQ_DEPTH];
    logic [IQ_AW-1:0] iq_rd_ptr;
    logic [IQ_AW-1:0] iq_wr_ptr;
    logic [IQ_AW:0]   iq_cnt;
    logic             iq_push;
    ex_op_t           head;
    logic             head_vld;
    logic             misalign;
    logic             ld_ok;
    logic             pend_st;
    logic             st_hazard;
    logic             out_free;
    logic             head_done;
    ld_state_e        ld_state;
    mem_info_t        info_d;

    assign iq_push    = ex_valid && !flush;   // sender holds credit, no full check
    assign head       = iq_mem[iq_rd_ptr];
    assign head_vld   = iq_cnt != '0;
    assign misalign   = head.addr[1:0] != 2'b00;
    assign ld_ok      = head_vld && head.op == OP_LOAD && !misalign;
    // an older store not yet in the store buffer
    assign st_hazard  = (mem_valid && mem_info.st_valid) || pend_st;
    assign out_free   = !mem_valid || mem_ready;
    assign fwd_addr   = head.addr[`DMEM_AW+1:2];
    assign credit_ret = head_done && !flush;

    always_comb begin
        head_done = 1'b0;
        if (head_vld && out_free) begin
            if (!ld_ok || ld_state == WAIT_DATA)
                head_done = 1'b1;
            else
                head_done = !st_hazard && fwd_hit;  // forwarded load
        end
    end

    always_comb begin
        ld_req      = '0;
        ld_req.en   = ld_ok && !st_hazard && !fwd_hit && ld_state != WAIT_DATA;
        ld_req.addr = fwd_addr;
    end

    always_comb begin
        info_d             = '0;
        info_d.pc          = head.pc;
        info_d.inst        = head.inst;
        info_d.except_type = EXC_NONE;
        case (head.op)
            OP_ALU: begin
                info_d.rw_addr = head.rd;
                info_d.rw_en   = 1'b1;
                info_d.rw_data = head.result;
            end
            OP_CSRW: begin
                info_d.csr_wen   = 1'b1;
                info_d.csr_waddr = head.addr[`CSR_ADDR_W-1:0];
                info_d.csr_wdata = head.result;
            end
            OP_LOAD: begin
                if (misalign) begin
                    info_d.except_type = EXC_LD_MISALIGN;
                end else begin
                    info_d.rw_addr = head.rd;
                    info_d.rw_en   = 1'b1;
                    // ram keeps rdata until the next read
                    info_d.rw_data = (ld_state == WAIT_DATA) ? ld_rdata : fwd_data;
                end
            end
            default: begin
                if (misalign) begin
                    info_d.except_type = EXC_ST_MISALIGN;
                end else begin
                    info_d.st_valid = 1'b1;
                    info_d.st_paddr = head.addr;
                    info_d.st_data  = head.st_data;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ld_state <= IDLE;
        end else if (head_done) begin
            ld_state <= IDLE;
        end else if (ld_req.en) begin
            ld_state <= ld_gnt ? WAIT_DATA : WAIT_GNT;
        end
    end

    always_ff @(posedge clk) begin
        if (iq_push)
            iq_mem[iq_wr_ptr] <= ex_op;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            iq_rd_ptr <= '0;
            iq_wr_ptr <= '0;
            iq_cnt    <= '0;
        end else begin
            if (iq_push)
                iq_wr_ptr <= iq_wr_ptr + 1'b1;
            if (head_done)
                iq_rd_ptr <= iq_rd_ptr + 1'b1;
            iq_cnt <= iq_cnt + (IQ_AW+1)'(iq_push) - (IQ_AW+1)'(head_done);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            mem_valid <= 1'b0;
            pend_st   <= 1'b0;
        end else begin
            if (out_free)
                mem_valid <= head_done;
            if (mem_ready)  // whatever sat in mem_wb retires now
                pend_st <= mem_valid && mem_info.st_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (head_done)
            mem_info <= info_d;
    end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             stall,
    input  logic             ex_valid,
    input  lsu_pkg::ex_op_t  ex_op,
    output logic             credit_ret,
    output logic             retire_valid,
    output lsu_pkg::retire_t retire
);
    import lsu_pkg::*;

    logic                mem_valid;
    logic                mem_ready;
    mem_info_t           mem_info;
    logic                wb_valid;
    logic                wb_ready;
    mem_info_t           wb_info;
    mem_req_t            ld_req;
    mem_req_t            st_req;
    mem_req_t            ram_req;
    logic                ld_gnt;
    logic                st_gnt;
    logic [`XLEN-1:0]    ram_rdata;
    logic [`DMEM_AW-1:0] fwd_addr;
    logic                fwd_hit;
    logic [`XLEN-1:0]    fwd_data;
    logic                sb_full;
    logic                sb_push;
    mem_req_t            sb_data;

    mem_stage u_mem (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .ex_valid(ex_valid), .ex_op(ex_op),
        .mem_ready(mem_ready), .ld_gnt(ld_gnt), .ld_rdata(ram_rdata),
        .fwd_hit(fwd_hit), .fwd_data(fwd_data),
        .credit_ret(credit_ret), .mem_valid(mem_valid), .mem_info(mem_info),
        .ld_req(ld_req), .fwd_addr(fwd_addr)
    );

    mem_wb_reg u_mem_wb (
        .clk(clk), .rst_n(rst_n), .flush(flush), .stall(stall),
        .mem_valid(mem_valid), .mem_info(mem_info), .wb_ready(wb_ready),
        .mem_ready(mem_ready), .wb_valid(wb_valid), .wb_info(wb_info)
    );

    wb_stage u_wb (
        .wb_valid(wb_valid), .wb_info(wb_info), .sb_full(sb_full),
        .wb_ready(wb_ready), .retire_valid(retire_valid), .retire(retire),
        .sb_push(sb_push), .sb_data(sb_data)
    );

    store_buffer u_sb (
        .clk(clk), .rst_n(rst_n), .sb_push(sb_push), .sb_data(sb_data),
        .st_gnt(st_gnt), .fwd_addr(fwd_addr), .sb_full(sb_full),
        .st_req(st_req), .fwd_hit(fwd_hit), .fwd_data(fwd_data)
    );

    dmem_arbiter u_arb (
        .clk(clk), .rst_n(rst_n), .ld_req(ld_req), .st_req(st_req),
        .sb_full(sb_full), .ld_gnt(ld_gnt), .st_gnt(st_gnt), .ram_req(ram_req)
    );

    data_ram u_ram (
        .clk(clk), .ram_req(ram_req), .rdata(ram_rdata)
    );

endmodule

// ==== lsu_chk.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_chk (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic stall,
    input logic ex_valid,
    input logic credit_ret,
    input logic wb_valid,
    input logic retire_valid,
    input logic ld_gnt,
    input logic st_gnt
);
    int ret_run;  // credits returned since the last send

    always_ff @(posedge clk) begin
        if (!rst_n || flush)
            ret_run <= 0;
        else if (ex_valid)
            ret_run <= int'(credit_ret);
        else
            ret_run <= ret_run + int'(credit_ret);
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        ret_run <= `IQ_DEPTH)
        else $error("more credit returns than queue entries without a send");

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(ld_gnt && st_gnt))
        else $error("load and store grants high together");

    a_stall_gates_wb: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !wb_valid)
        else $error("wb_valid high during stall");

    // first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid)
        else $error("retire_valid high right after reset");

endmodule

bind lsu_top lsu_chk chk_i (
    .clk(clk), .rst_n(rst_n), .flush(flush), .stall(stall),
    .ex_valid(ex_valid), .credit_ret(credit_ret),
    .wb_valid(wb_valid), .retire_valid(retire_valid),
    .ld_gnt(ld_gnt), .st_gnt(st_gnt)
);

// ==== tb_lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int RUN_CYCLES  = 4000;
    localparam int HANG_LIMIT  = 200;   // cycles with work pending and nothing retiring
    localparam int DRAIN_LIMIT = 500;

    logic    clk;
    logic    rst_n;
    logic    flush;
    logic    stall;
    logic    ex_valid;
    ex_op_t  ex_op;
    logic    credit_ret;
    logic    retire_valid;
    retire_t retire;

    ex_op_t           sent_q[$];   // sent and not yet retired, oldest first
    logic [`XLEN-1:0] model_mem [`DMEM_WORDS];
    int               credits;
    int               stall_left;
    int               retired;
    logic [`XLEN-1:0] next_pc;

    lsu_top dut_i (
        .clk(clk), .rst_n(rst_n), .flush(flush), .stall(stall),
        .ex_valid(ex_valid), .ex_op(ex_op),
        .credit_ret(credit_ret), .retire_valid(retire_valid), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic expect_equal(input string name, input logic [`XLEN-1:0] exp,
                                input logic [`XLEN-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            fail_run("value mismatch");
        end
    endtask

    function automatic ex_op_t random_op(input logic [`XLEN-1:0] pc);
        ex_op_t           o;
        logic [`XLEN-1:0] waddr;
        o         = '0;
        o.op      = lsu_op_e'(2'($urandom_range(3, 0)));
        o.pc      = pc;
        o.inst    = $urandom;
        o.rd      = 5'($urandom_range(31, 1));
        o.result  = $urandom;
        o.st_data = $urandom;
        waddr     = $urandom_range(15, 0);  // few words, so loads hit recent stores
        o.addr    = waddr << 2;
        if ($urandom_range(7, 0) == 0)
            o.addr[1:0] = 2'($urandom_range(3, 1));
        if (o.op == OP_CSRW)
            o.addr = $urandom_range(4095, 0);  // csr index
        return o;
    endfunction

    task automatic drive_inputs();
        if (stall_left > 0) begin
            stall = 1'b1;
            stall_left--;
        end else begin
            stall = 1'b0;
            if ($urandom_range(15, 0) == 0)
                stall_left = $urandom_range(8, 1);
        end
        flush    = $urandom_range(79, 0) == 0;
        ex_valid = 1'b0;
        if (credits > 0 && $urandom_range(3, 0) != 0) begin
            ex_valid = 1'b1;
            ex_op    = random_op(next_pc);
            next_pc  = next_pc + 32'd4;
            credits--;
        end
    endtask

    task automatic score_retire();
        ex_op_t  op;
        logic    mis;
        logic    exp_rw;
        int      idx;
        except_e exp_exc;
        if (sent_q.size() == 0) begin
            fail_run("a record retired with no operation outstanding");
        end else begin
            op      = sent_q.pop_front();
            mis     = op.addr[1:0] != 2'b00;
            idx     = int'(op.addr[`DMEM_AW+1:2]);
            exp_exc = EXC_NONE;
            if (mis && op.op == OP_LOAD)
                exp_exc = EXC_LD_MISALIGN;
            if (mis && op.op == OP_STORE)
                exp_exc = EXC_ST_MISALIGN;
            exp_rw = exp_exc == EXC_NONE && (op.op == OP_ALU || op.op == OP_LOAD);
            retired++;
            expect_equal("retire_pc", op.pc, retire.pc);
            expect_equal("except_type", 32'(exp_exc), 32'(retire.except_type));
            expect_equal("rw_en", 32'(exp_rw), 32'(retire.rw_en));
            expect_equal("csr_wen", 32'(op.op == OP_CSRW), 32'(retire.csr_wen));
            if (exp_rw)
                expect_equal("rd", 32'(op.rd), 32'(retire.rd));
            case (op.op)
                OP_ALU: begin
                    expect_equal("alu_rw_data", op.result, retire.rw_data);
                end
                OP_LOAD: begin
                    if (!mis)
                        expect_equal("load_data", model_mem[idx], retire.rw_data);
                end
                OP_STORE: begin
                    if (!mis)
                        model_mem[idx] = op.st_data;  // memory follows retire order
                end
                default: begin
                    expect_equal("csr_waddr", 32'(op.addr[`CSR_ADDR_W-1:0]),
                                 32'(retire.csr_waddr));
                    expect_equal("csr_wdata", op.result, retire.csr_wdata);
                end
            endcase
        end
    endtask

    // called in the active region of the rising edge, before any NBA update
    task automatic sample_outputs();
        if (stall)
            expect_equal("stall_blocks_retire", 32'd0, 32'(retire_valid));
        if (retire_valid)
            score_retire();
        if (flush) begin
            sent_q.delete();  // dropped, must never retire
            credits = `IQ_DEPTH;
        end else begin
            if (credit_ret)
                credits++;
            if (ex_valid)
                sent_q.push_back(ex_op);
        end
        expect_equal("credit_in_range", 32'd1, 32'(credits >= 0 && credits <= `IQ_DEPTH));
    endtask

    initial begin
        int idle;
        int waited;
        void'($urandom(32'h67ce));
        rst_n      = 1'b0;
        flush      = 1'b0;
        stall      = 1'b0;
        ex_valid   = 1'b0;
        ex_op      = '0;
        credits    = `IQ_DEPTH;
        stall_left = 0;
        retired    = 0;
        next_pc    = 32'h1000;
        idle       = 0;
        waited     = 0;
        for (int i = 0; i < `DMEM_WORDS; i++)
            model_mem[i] = '0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int cyc = 0; cyc < RUN_CYCLES && idle <= HANG_LIMIT; cyc++) begin
            @(negedge clk);
            drive_inputs();
            @(posedge clk);
            sample_outputs();
            if (retire_valid || sent_q.size() == 0)
                idle = 0;
            else
                idle++;
        end

        if (idle > HANG_LIMIT) begin
            fail_run("pipeline made no progress with operations outstanding");
        end else begin
            @(negedge clk);
            stall    = 1'b0;
            flush    = 1'b0;
            ex_valid = 1'b0;
            while (sent_q.size() != 0 && waited < DRAIN_LIMIT) begin
                @(posedge clk);
                sample_outputs();
                waited++;
            end
            if (sent_q.size() != 0) begin
                fail_run("outstanding operations did not retire before the drain timeout");
            end else begin
                expect_equal("final_credits", `IQ_DEPTH, credits);
                expect_equal("enough_retired", 32'd1, 32'(retired > 100));
                $display("TB PASSED");
                $finish;
            end
        end
    end

endmodule

// ==== verilog.f ====
+incdir+.
lsu_pkg.sv
data_ram.sv
dmem_arbiter.sv
store_buffer.sv
wb_stage.sv
mem_wb_reg.sv
mem_stage.sv
lsu_top.sv
lsu_chk.sv
tb_lsu_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_lsu_top
FILELIST := verilog.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
